/* hw/bomberman_pkg.sv */
`default_nettype none

package bomberman_pkg;

    // --------------------
    // map geometry
    // --------------------
    localparam int NUM_ROW    = 11;                    // tiles down
    localparam int NUM_COL    = 19;                    // tiles across
    localparam int TILE_PX    = 64;                    // tile edge in pixels
    localparam int TILE_SHIFT = $clog2(TILE_PX);       // pixel -> tile index

    // player sprite box, top left corner is the player position
    localparam int SPRITE_W   = 32;
    localparam int SPRITE_H   = 48;

    // tile memory, address = row * NUM_COL + col
    localparam int MAP_DEPTH  = NUM_ROW * NUM_COL;     // 209 entries
    localparam int ADDR_W     = $clog2(MAP_DEPTH);     // 8 bits
    localparam int TILE_W     = 2;

    // --------------------
    // tile and item codes
    // --------------------
    typedef enum logic [TILE_W-1:0] {
        TILE_EMPTY = 2'd0,
        TILE_BRICK = 2'd1,                             // breakable
        TILE_WALL  = 2'd2                              // border and pillars
    } tile_t;

    typedef enum logic {
        ITEM_IDLE   = 1'b0,
        ITEM_ACTIVE = 1'b1
    } item_state_t;

    // --------------------
    // timing
    // --------------------
    localparam int ITEM_TIME     = 6;                  // item lifetime, seconds
    localparam int TICKS_PER_SEC = 60;                 // frame ticks per second
    localparam int SEC_CNT_W     = $clog2(TICKS_PER_SEC);

    // short divider for simulation, real video would be ~1.6M cycles
    localparam int TICK_DIV      = 4;
    localparam int TICK_CNT_W    = $clog2(TICK_DIV);

    // random item generation
    localparam int PROB_W        = 32;                 // threshold width
    localparam logic [PROB_W-1:0] LFSR_SEED = 32'hACE1_2468;  // any nonzero value

endpackage

`default_nettype wire

/* hw/pbit.sv */
`timescale 1ns/1ps
`default_nettype none

// random bit source, high with chance threshold / 2^32
module pbit (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [bomberman_pkg::PROB_W-1:0] threshold,
    output logic                             bit_out
);

    logic [bomberman_pkg::PROB_W-1:0] lfsr;       // fibonacci shift register
    logic                             feedback;

    // x^32 + x^22 + x^2 + x + 1, maximal length
    assign feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr    <= bomberman_pkg::LFSR_SEED;
            bit_out <= 1'b0;
        end else begin
            lfsr    <= {lfsr[30:0], feedback};     // one step per cycle
            bit_out <= (lfsr <= threshold);        // zero never fires, all ones always does
        end
    end

    // all-zero state would lock up the sequence
    lfsr_nonzero: assert property (@(posedge clk) disable iff (rst)
        lfsr != '0)
        else $error("pbit: lfsr reached the all-zero state");

endmodule

`default_nettype wire

/* hw/map_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// tile memory, two registered read ports and one write port
module map_ram (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [bomberman_pkg::ADDR_W-1:0] clr_rd_addr,   // clearer side
    input  logic [bomberman_pkg::ADDR_W-1:0] ext_rd_addr,   // outside side
    output bomberman_pkg::tile_t             clr_rd_data,
    output bomberman_pkg::tile_t             ext_rd_data,
    input  logic                             wr_en,
    input  logic [bomberman_pkg::ADDR_W-1:0] wr_addr,
    input  bomberman_pkg::tile_t             wr_data
);

    bomberman_pkg::tile_t mem [bomberman_pkg::MAP_DEPTH];

    // level layout: walls on border and even/even pillars, bricks on every third diagonal
    function automatic bomberman_pkg::tile_t level_tile(input int row, input int col);
        logic border;
        logic pillar;
        border = (row == 0) || (col == 0) ||
                 (row == bomberman_pkg::NUM_ROW - 1) || (col == bomberman_pkg::NUM_COL - 1);
        pillar = ((row % 2) == 0) && ((col % 2) == 0);
        if (border || pillar) begin
            return bomberman_pkg::TILE_WALL;
        end
        if (((row + col) % 3) == 0) begin
            return bomberman_pkg::TILE_BRICK;
        end
        return bomberman_pkg::TILE_EMPTY;
    endfunction

    // --------------------
    // level load and write
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < bomberman_pkg::NUM_ROW; r++) begin
                for (int c = 0; c < bomberman_pkg::NUM_COL; c++) begin
                    mem[r * bomberman_pkg::NUM_COL + c] <= level_tile(r, c);
                end
            end
        end else if (wr_en && (wr_addr < bomberman_pkg::MAP_DEPTH)) begin
            mem[wr_addr] <= wr_data;                 // seen by reads next cycle
        end
    end

    // registered reads, out-of-range reads back as wall
    always_ff @(posedge clk) begin
        clr_rd_data <= (clr_rd_addr < bomberman_pkg::MAP_DEPTH) ?
                       mem[clr_rd_addr] : bomberman_pkg::TILE_WALL;
        ext_rd_data <= (ext_rd_addr < bomberman_pkg::MAP_DEPTH) ?
                       mem[ext_rd_addr] : bomberman_pkg::TILE_WALL;
    end

    wr_in_range: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (wr_addr < bomberman_pkg::MAP_DEPTH))
        else $error("map_ram: write to address %0d beyond the map", wr_addr);

endmodule

`default_nettype wire

/* hw/frame_tick.sv */
`timescale 1ns/1ps
`default_nettype none

// one-cycle frame strobe every TICK_DIV clocks
module frame_tick (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [bomberman_pkg::TICK_CNT_W-1:0] cnt;   // position inside the frame

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == (bomberman_pkg::TICK_CNT_W)'(bomberman_pkg::TICK_DIV - 1)) begin
            cnt  <= '0;                               // wrap
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/brick_clearer.sv */
`timescale 1ns/1ps
`default_nettype none

// turns a brick hit by an explosion into an empty tile
module brick_clearer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             clear_req,   // one-cycle strobe
    input  logic [bomberman_pkg::ADDR_W-1:0] clear_addr,
    output logic [bomberman_pkg::ADDR_W-1:0] rd_addr,
    input  bomberman_pkg::tile_t             rd_data,     // one cycle after rd_addr
    output logic                             wr_en,
    output logic [bomberman_pkg::ADDR_W-1:0] wr_addr,
    output bomberman_pkg::tile_t             wr_data
);

    // --------------------
    // request tracking
    // --------------------
    logic                             busy;       // a request is in flight
    logic                             chk;        // rd_data holds the pending tile
    logic [bomberman_pkg::ADDR_W-1:0] pend_addr;  // tile under test
    logic                             accept;

    // requests seen while busy are lost
    assign accept = clear_req && !busy;

    // busy spans the read cycle and the check cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            chk  <= 1'b0;
        end else if (!busy) begin
            busy <= clear_req;
            chk  <= 1'b0;
        end else begin
            chk  <= !chk;                     // read -> check
            busy <= !chk;                     // free after check
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_addr <= clear_addr;
        end
    end

    // --------------------
    // memory access
    // --------------------
    assign rd_addr = pend_addr;               // read lands on the edge after accept

    // only bricks get rewritten, walls and empty tiles stay as they are
    assign wr_en   = chk && (rd_data == bomberman_pkg::TILE_BRICK);
    assign wr_addr = pend_addr;
    assign wr_data = bomberman_pkg::TILE_EMPTY;

    // one write per request, so never two in a row
    single_write: assert property (@(posedge clk) disable iff (rst)
        wr_en |=> !wr_en)
        else $error("brick_clearer: back-to-back writes");

endmodule

`default_nettype wire

/* hw/item_generator.sv */
`timescale 1ns/1ps
`default_nettype none

// places at most one item on a freed tile and times its lifetime
module item_generator #(
    parameter int ITEM_TIME = bomberman_pkg::ITEM_TIME    // seconds
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             tick,          // frame strobe
    input  logic                             free_we,       // map write from the clearer
    input  logic [bomberman_pkg::ADDR_W-1:0] free_addr,
    input  bomberman_pkg::tile_t             free_data,
    input  logic [10:0]                      player_x,      // pixels
    input  logic [9:0]                       player_y,
    input  logic [bomberman_pkg::PROB_W-1:0] probability,
    output logic [bomberman_pkg::ADDR_W-1:0] item_addr,
    output logic                             item_active,
    output logic                             player_on_item
);

    bomberman_pkg::item_state_t st, nst;

    logic                                gen_bit;      // random decision
    logic                                spawn;        // freed tile gets an item
    logic                                last_tick;    // final tick of the lifetime
    logic [bomberman_pkg::SEC_CNT_W-1:0] sec_cnt;      // ticks inside the second
    logic [$clog2(ITEM_TIME + 1)-1:0]    countdown;    // seconds left

    pbit item_pbit (
        .clk       (clk),
        .rst       (rst),
        .threshold (probability),
        .bit_out   (gen_bit)
    );

    assign spawn     = free_we && (free_data == bomberman_pkg::TILE_EMPTY) && gen_bit;
    assign last_tick = tick && (countdown == 1) &&
                       (sec_cnt == (bomberman_pkg::SEC_CNT_W)'(bomberman_pkg::TICKS_PER_SEC - 1));

    // --------------------
    // state machine
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            st <= bomberman_pkg::ITEM_IDLE;
        end else begin
            st <= nst;
        end
    end

    always_comb begin
        nst = st;
        case (st)
            bomberman_pkg::ITEM_IDLE: begin
                if (spawn) begin
                    nst = bomberman_pkg::ITEM_ACTIVE;
                end
            end
            bomberman_pkg::ITEM_ACTIVE: begin
                if (last_tick) begin
                    nst = bomberman_pkg::ITEM_IDLE;   // lifetime over
                end
            end
            default: nst = bomberman_pkg::ITEM_IDLE;
        endcase
    end

    // lifetime counters and item position
    always_ff @(posedge clk) begin
        if (rst) begin
            sec_cnt   <= '0;
            countdown <= ($clog2(ITEM_TIME + 1))'(ITEM_TIME);
            item_addr <= '0;
        end else if (st == bomberman_pkg::ITEM_IDLE) begin
            sec_cnt   <= '0;                                    // fresh lifetime
            countdown <= ($clog2(ITEM_TIME + 1))'(ITEM_TIME);
            if (spawn) begin
                item_addr <= free_addr;
            end
        end else if (tick) begin
            // frees while active still reach the map but never move the item
            if (sec_cnt == (bomberman_pkg::SEC_CNT_W)'(bomberman_pkg::TICKS_PER_SEC - 1)) begin
                sec_cnt   <= '0;
                countdown <= countdown - 1'b1;
            end else begin
                sec_cnt   <= sec_cnt + 1'b1;
            end
        end
    end

    assign item_active = (st == bomberman_pkg::ITEM_ACTIVE);

    // --------------------
    // player overlap
    // --------------------
    logic [10-bomberman_pkg::TILE_SHIFT:0] col1, col2;     // tile columns
    logic [9-bomberman_pkg::TILE_SHIFT:0]  row1, row2;     // tile rows
    logic [bomberman_pkg::TILE_SHIFT:0]    right_off;      // right edge inside tile
    logic [bomberman_pkg::TILE_SHIFT:0]    bottom_off;
    logic [bomberman_pkg::ADDR_W-1:0]      blk1_addr, blk2_addr;

    assign col1 = player_x[10:bomberman_pkg::TILE_SHIFT];
    assign row1 = player_y[9:bomberman_pkg::TILE_SHIFT];

    assign right_off  = {1'b0, player_x[bomberman_pkg::TILE_SHIFT-1:0]} +
                        (bomberman_pkg::TILE_SHIFT + 1)'(bomberman_pkg::SPRITE_W);
    assign bottom_off = {1'b0, player_y[bomberman_pkg::TILE_SHIFT-1:0]} +
                        (bomberman_pkg::TILE_SHIFT + 1)'(bomberman_pkg::SPRITE_H);

    // second tile only moves when the sprite spills over the edge
    assign col2 = (right_off > bomberman_pkg::TILE_PX) ? col1 + 1'b1 : col1;
    assign row2 = (bottom_off > bomberman_pkg::TILE_PX) ? row1 + 1'b1 : row1;

    assign blk1_addr = (bomberman_pkg::ADDR_W)'(row1 * bomberman_pkg::NUM_COL + col1);
    assign blk2_addr = (bomberman_pkg::ADDR_W)'(row2 * bomberman_pkg::NUM_COL + col2);

    assign player_on_item = item_active && ((blk1_addr == item_addr) || (blk2_addr == item_addr));

    // item cannot hop tiles during its lifetime
    addr_hold: assert property (@(posedge clk) disable iff (rst)
        item_active |=> (!item_active || $stable(item_addr)))
        else $error("item_generator: item_addr moved while active");

endmodule

`default_nettype wire

/* hw/map_item_top.sv */
`timescale 1ns/1ps
`default_nettype none

// map and item core: tick, tile memory, brick clearing, item timing
module map_item_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             clear_req,
    input  logic [bomberman_pkg::ADDR_W-1:0] clear_addr,
    input  logic [bomberman_pkg::PROB_W-1:0] probability,
    input  logic [10:0]                      player_x,
    input  logic [9:0]                       player_y,
    input  logic [bomberman_pkg::ADDR_W-1:0] map_rd_addr,
    output bomberman_pkg::tile_t             map_rd_data,
    output logic [bomberman_pkg::ADDR_W-1:0] item_addr,
    output logic                             item_active,
    output logic                             player_on_item
);

    logic                             tick;          // frame strobe
    logic [bomberman_pkg::ADDR_W-1:0] clr_rd_addr;   // clearer read port
    bomberman_pkg::tile_t             clr_rd_data;
    logic                             wr_en;         // clearer write, also the free strobe
    logic [bomberman_pkg::ADDR_W-1:0] wr_addr;
    bomberman_pkg::tile_t             wr_data;

    frame_tick frame_tick_inst (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    map_ram map_ram_inst (
        .clk         (clk),
        .rst         (rst),
        .clr_rd_addr (clr_rd_addr),
        .ext_rd_addr (map_rd_addr),
        .clr_rd_data (clr_rd_data),
        .ext_rd_data (map_rd_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    brick_clearer brick_clearer_inst (
        .clk        (clk),
        .rst        (rst),
        .clear_req  (clear_req),
        .clear_addr (clear_addr),
        .rd_addr    (clr_rd_addr),
        .rd_data    (clr_rd_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    item_generator item_generator_inst (
        .clk            (clk),
        .rst            (rst),
        .tick           (tick),
        .free_we        (wr_en),
        .free_addr      (wr_addr),
        .free_data      (wr_data),
        .player_x       (player_x),
        .player_y       (player_y),
        .probability    (probability),
        .item_addr      (item_addr),
        .item_active    (item_active),
        .player_on_item (player_on_item)
    );

endmodule

`default_nettype wire

/* verif/map_item_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module map_item_tb;

    localparam int DIV         = bomberman_pkg::TICK_DIV;
    localparam int LIFE_CYC    = bomberman_pkg::ITEM_TIME * bomberman_pkg::TICKS_PER_SEC * DIV;
    localparam int TIMEOUT_CYC = 6 * (LIFE_CYC + 64);      // about six item lifetimes
    localparam int AW          = bomberman_pkg::ADDR_W;

    logic                             clk;
    logic                             rst;
    logic                             clear_req;
    logic [AW-1:0]                    clear_addr;
    logic [bomberman_pkg::PROB_W-1:0] probability;
    logic [10:0]                      player_x;
    logic [9:0]                       player_y;
    logic [AW-1:0]                    map_rd_addr;
    bomberman_pkg::tile_t             map_rd_data;
    logic [AW-1:0]                    item_addr;
    logic                             item_active;
    logic                             player_on_item;

    // reference model state
    bomberman_pkg::tile_t model_map [bomberman_pkg::MAP_DEPTH];
    bomberman_pkg::tile_t exp_rd;          // expected map_rd_data
    logic                 rd_valid;
    logic [1:0]           stage;           // 0 idle, 1 read, 2 check
    logic [AW-1:0]        pend;
    logic                 gen_ok;          // registered random bit, known for 0 and all ones
    logic                 m_item;
    logic [AW-1:0]        m_item_addr;
    int                   m_life;          // cycles since item rose
    logic                 ending;
    int                   seed = 67529;
    int                   cycles = 0;

    map_item_top map_item_top_inst (
        .clk            (clk),
        .rst            (rst),
        .clear_req      (clear_req),
        .clear_addr     (clear_addr),
        .probability    (probability),
        .player_x       (player_x),
        .player_y       (player_y),
        .map_rd_addr    (map_rd_addr),
        .map_rd_data    (map_rd_data),
        .item_addr      (item_addr),
        .item_active    (item_active),
        .player_on_item (player_on_item)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                // 40 ns period
    end

    // --------------------
    // error handling
    // --------------------
    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        stop_run();
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("MISMATCH time=%0t signal=%s got=%0d expected=%0d", $time, name, got, exp);
        stop_run();
    endtask

    // --------------------
    // reference rules
    // --------------------
    function automatic bomberman_pkg::tile_t level_at(input int addr);
        int  row;
        int  col;
        logic edge_tile;
        row = addr / bomberman_pkg::NUM_COL;
        col = addr % bomberman_pkg::NUM_COL;
        edge_tile = (row == 0) || (col == 0) || (row == bomberman_pkg::NUM_ROW - 1) ||
                    (col == bomberman_pkg::NUM_COL - 1);
        return (edge_tile || (row % 2 == 0 && col % 2 == 0)) ? bomberman_pkg::TILE_WALL :
               ((row + col) % 3 == 0) ? bomberman_pkg::TILE_BRICK : bomberman_pkg::TILE_EMPTY;
    endfunction

    // first tile under the top left corner, second under the bottom right corner
    function automatic logic covers(input int x, input int y, input int tile);
        int first;
        int last;
        first = (y >> bomberman_pkg::TILE_SHIFT) * bomberman_pkg::NUM_COL +
                (x >> bomberman_pkg::TILE_SHIFT);
        last  = ((y + bomberman_pkg::SPRITE_H - 1) >> bomberman_pkg::TILE_SHIFT) *
                bomberman_pkg::NUM_COL + ((x + bomberman_pkg::SPRITE_W - 1) >> bomberman_pkg::TILE_SHIFT);
        return (first == tile) || (last == tile);
    endfunction

    // item may end anywhere inside the tick-phase window
    assign ending = m_item && !item_active && (m_life >= LIFE_CYC - DIV);

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bomberman_pkg::MAP_DEPTH; i++) begin
                model_map[i] <= level_at(i);
            end
            exp_rd      <= bomberman_pkg::TILE_EMPTY;
            rd_valid    <= 1'b0;
            stage       <= 2'd0;
            pend        <= '0;
            gen_ok      <= 1'b0;
            m_item      <= 1'b0;
            m_item_addr <= '0;
            m_life      <= 0;
        end else begin
            rd_valid <= 1'b1;
            exp_rd   <= model_map[map_rd_addr];              // value before any write this edge
            gen_ok   <= (probability == '1);
            if (m_item) m_life <= m_life + 1;
            if (ending) m_item <= 1'b0;
            case (stage)
                2'd0: if (clear_req) begin
                    stage <= 2'd1;
                    pend  <= clear_addr;
                end
                2'd1: stage <= 2'd2;
                default: begin
                    stage <= 2'd0;
                    if (model_map[pend] == bomberman_pkg::TILE_BRICK) begin
                        model_map[pend] <= bomberman_pkg::TILE_EMPTY;
                        if ((!m_item || ending) && gen_ok) begin   // one item at a time
                            m_item      <= 1'b1;
                            m_item_addr <= pend;
                            m_life      <= 0;
                        end
                    end
                end
            endcase
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) abort_run("timeout: the run went past its cycle limit");
    end

    // --------------------
    // checks
    // --------------------
    map_read_check: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> (map_rd_data == exp_rd))
        else report_mismatch("map_rd_data", $sampled(map_rd_data), $sampled(exp_rd));

    item_addr_check: assert property (@(posedge clk) disable iff (rst)
        item_addr == m_item_addr)
        else report_mismatch("item_addr", $sampled(item_addr), $sampled(m_item_addr));

    idle_check: assert property (@(posedge clk) disable iff (rst)
        !m_item |-> !item_active)
        else report_mismatch("item_active", $sampled(item_active), 0);

    hold_check: assert property (@(posedge clk) disable iff (rst)
        (m_item && m_life < LIFE_CYC - DIV) |-> item_active)
        else report_mismatch("item_active", $sampled(item_active), 1);

    expire_check: assert property (@(posedge clk) disable iff (rst)
        (m_item && m_life >= LIFE_CYC + DIV) |-> !item_active)
        else report_mismatch("item_active", $sampled(item_active), 0);

    overlap_check: assert property (@(posedge clk) disable iff (rst)
        (m_item && m_life < LIFE_CYC - DIV) |->
        (player_on_item == covers(player_x, player_y, m_item_addr)))
        else report_mismatch("player_on_item", $sampled(player_on_item),
                             covers($sampled(player_x), $sampled(player_y), $sampled(m_item_addr)));

    idle_overlap_check: assert property (@(posedge clk) disable iff (rst)
        !m_item |-> !player_on_item)
        else report_mismatch("player_on_item", $sampled(player_on_item), 0);

    // --------------------
    // stimulus
    // --------------------
    task automatic clear_tile(input int addr);
        @(negedge clk);
        clear_req  = 1'b1;
        clear_addr = AW'(addr);
        @(negedge clk);
        clear_req  = 1'b0;
        repeat (3) @(negedge clk);                      // write has landed
        map_rd_addr = AW'(addr);                        // read the tile back
        repeat (2) @(negedge clk);
    endtask

    task automatic pick_brick(output logic [AW-1:0] addr);
        int draw;
        addr = '0;                                      // corner wall, forces a draw
        while (model_map[addr] != bomberman_pkg::TILE_BRICK) begin
            draw = $random(seed);
            addr = AW'($unsigned(draw) % bomberman_pkg::MAP_DEPTH);
        end
    endtask

    task automatic place_player(input int x, input int y);
        @(negedge clk);
        player_x = 11'(x);
        player_y = 10'(y);
        repeat (3) @(negedge clk);
    endtask

    task automatic wait_item(input logic level, input int limit);
        int n;
        n = 0;
        while (item_active !== level && n <= limit) begin
            @(negedge clk);
            n++;
        end
        if (item_active !== level) abort_run("item_active did not reach the expected level in time");
    endtask

    initial begin : stimulus
        logic [AW-1:0] b1;
        logic [AW-1:0] b2;
        int            r;
        int            c;
        rst         = 1'b1;
        clear_req   = 1'b0;
        clear_addr  = '0;
        probability = '0;
        player_x    = '0;
        player_y    = '0;
        map_rd_addr = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        for (int a = 0; a < bomberman_pkg::MAP_DEPTH; a++) begin   // full map sweep
            @(negedge clk);
            map_rd_addr = AW'(a);
        end
        @(negedge clk);

        clear_tile(0);                                  // corner wall
        clear_tile(bomberman_pkg::NUM_COL + 1);         // row 1 col 1, empty
        pick_brick(b1);
        clear_tile(b1);                                 // probability 0, no item

        probability = '1;                               // always spawn
        pick_brick(b1);
        clear_tile(b1);
        wait_item(1'b1, 8);
        pick_brick(b2);
        clear_tile(b2);                                 // freed while active, item stays

        r = b1 / bomberman_pkg::NUM_COL;
        c = b1 % bomberman_pkg::NUM_COL;
        place_player(c * 64 + 16, r * 64 + 8);          // inside
        place_player((c - 1) * 64 + 48, r * 64 + 8);    // spills in from the left
        place_player(c * 64 + 16, (r - 1) * 64 + 40);   // spills in from above
        place_player((c - 1) * 64 + 48, (r - 1) * 64 + 40);
        place_player((c - 1) * 64 + 48, r * 64 + 40);   // corner tiles miss the item
        place_player(c * 64 + 16, (r + 1) * 64 + 8);    // tile below
        place_player(c * 64 + 16, r * 64 + 8);
        wait_item(1'b0, LIFE_CYC + 4 * DIV);
        repeat (4) @(negedge clk);                      // expired, player still on the tile

        pick_brick(b2);                                 // second item after expiry
        clear_tile(b2);
        wait_item(1'b1, 8);
        place_player((b2 % bomberman_pkg::NUM_COL) * 64, (b2 / bomberman_pkg::NUM_COL) * 64);
        wait_item(1'b0, LIFE_CYC + 4 * DIV);
        repeat (4) @(negedge clk);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hw/bomberman_pkg.sv
hw/pbit.sv
hw/map_ram.sv
hw/frame_tick.sv
hw/brick_clearer.sv
hw/item_generator.sv
hw/map_item_top.sv
verif/map_item_tb.sv

/* Bender.yml */
package:
  name: map_item

sources:
  - files:
      - hw/bomberman_pkg.sv
      - hw/pbit.sv
      - hw/map_ram.sv
      - hw/frame_tick.sv
      - hw/brick_clearer.sv
      - hw/item_generator.sv
      - hw/map_item_top.sv
  - target: test
    files:
      - verif/map_item_tb.sv
